// ==== compile.f ====
src/soc_pkg.sv
src/bus_arbiter.sv
src/address_decoder.sv
src/block_ram.sv
src/system_regs.sv
src/soc_fabric.sv
verification/tb_clock_gen.sv
verification/soc_fabric_checker.sv
verification/tb_soc_fabric.sv

// ==== run.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f compile.f --top-module tb_soc_fabric

status=0
./obj_dir/Vtb_soc_fabric > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Errors found" sim.log || ! grep -q "No errors" sim.log; then
	echo "Simulation FAILED (exit status $status)"
	exit 1
fi
echo "Simulation PASSED"

// ==== src/address_decoder.sv ====
`default_nettype none

module address_decoder (
	input  wire                             clock,
	input  wire                             i_arst_n,
	input  wire                             i_bus_req,
	input  soc_pkg::bus_req_t               i_bus,
	output soc_pkg::target_sel_t            o_sel,
	output logic                            o_bus_ready,
	output logic [soc_pkg::data_w-1:0]      o_bus_rdata,
	input  wire                             i_ram_ready,
	input  wire [soc_pkg::data_w-1:0]       i_ram_rdata,
	input  wire                             i_regs_ready,
	input  wire [soc_pkg::data_w-1:0]       i_regs_rdata
);

	logic none_ready_q;

	// ====================
	// Region decode
	// ====================
	always_comb
	begin
		o_sel = '0;
		if (i_bus_req)
		begin
			case (soc_pkg::region_e'(i_bus.addr[soc_pkg::region_msb:soc_pkg::region_lsb]))
				soc_pkg::REGION_RAM:
					o_sel.ram = 1'b1;
				soc_pkg::REGION_LED:
					o_sel.led = 1'b1;
				soc_pkg::REGION_TIMER:
					o_sel.timer = 1'b1;
				default:
					o_sel.none = 1'b1;
			endcase
		end
	end

	// Unmapped space answers like a target, one cycle late
	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
			none_ready_q <= 1'b0;
		else
			none_ready_q <= o_sel.none && !none_ready_q;
	end

	// ====================
	// Response merge
	// ====================
	assign o_bus_ready = (o_sel.ram & i_ram_ready)
		| ((o_sel.led | o_sel.timer) & i_regs_ready)
		| (o_sel.none & none_ready_q);

	// Unmapped reads return zero
	assign o_bus_rdata = o_sel.ram ? i_ram_rdata
		: (o_sel.led | o_sel.timer) ? i_regs_rdata
		: '0;

endmodule

`default_nettype wire

// ==== src/block_ram.sv ====
`default_nettype none

module block_ram (
	input  wire                             clock,
	input  wire                             i_arst_n,
	input  wire                             i_sel,
	input  soc_pkg::bus_req_t               i_bus,
	output logic                            o_ready,
	output logic [soc_pkg::data_w-1:0]      o_rdata
);

	logic [soc_pkg::data_w-1:0] mem [soc_pkg::ram_words];
	logic [soc_pkg::ram_addr_w-1:0] index;
	logic access;

	// Word index, upper bits of the region alias
	assign index = i_bus.addr[soc_pkg::ram_addr_w+1:2];

	// Select stays high while ready is out, so one access only
	assign access = i_sel && !o_ready;

	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_ready <= 1'b0;
		else
			o_ready <= access;
	end

	always_ff @(posedge clock)
	begin
		if (access)
		begin
			if (i_bus.rw)
				mem[index] <= i_bus.wdata;
			o_rdata <= mem[index];
		end
	end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`default_nettype none

module bus_arbiter (
	input  wire                             clock,
	input  wire                             i_arst_n,
	input  wire                             i_pa_req,
	input  wire [soc_pkg::addr_w-1:0]       i_pa_addr,
	output logic                            o_pa_ready,
	output logic [soc_pkg::data_w-1:0]      o_pa_rdata,
	input  wire                             i_pb_req,
	input  soc_pkg::bus_req_t               i_pb,
	output logic                            o_pb_ready,
	output logic [soc_pkg::data_w-1:0]      o_pb_rdata,
	input  wire                             i_pc_req,
	input  soc_pkg::bus_req_t               i_pc,
	output logic                            o_pc_ready,
	output logic [soc_pkg::data_w-1:0]      o_pc_rdata,
	output logic                            o_bus_req,
	output soc_pkg::bus_req_t               o_bus,
	input  wire                             i_bus_ready,
	input  wire [soc_pkg::data_w-1:0]       i_bus_rdata
);

	soc_pkg::arb_state_e state_q;
	soc_pkg::master_e owner_q;
	soc_pkg::master_e winner;
	soc_pkg::bus_req_t bus_q;
	logic [soc_pkg::data_w-1:0] rdata_q;
	logic any_req;

	assign any_req = i_pa_req | i_pb_req | i_pc_req;

	// Fixed priority, data port first, then fetch, then DMA
	always_comb
	begin
		if (i_pb_req)
			winner = soc_pkg::MASTER_B;
		else if (i_pa_req)
			winner = soc_pkg::MASTER_A;
		else
			winner = soc_pkg::MASTER_C;
	end

	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			state_q <= soc_pkg::ARB_IDLE;
			owner_q <= soc_pkg::MASTER_A;
		end
		else
		begin
			case (state_q)
				soc_pkg::ARB_IDLE:
					if (any_req)
					begin
						state_q <= soc_pkg::ARB_BUS;
						owner_q <= winner;
					end
				soc_pkg::ARB_BUS:
					if (i_bus_ready)
						state_q <= soc_pkg::ARB_RESP;
				default:
					state_q <= soc_pkg::ARB_IDLE;
			endcase
		end
	end

	// Request fields and read data of the current owner
	always_ff @(posedge clock)
	begin
		if (state_q == soc_pkg::ARB_IDLE && any_req)
		begin
			case (winner)
				soc_pkg::MASTER_B:
					bus_q <= i_pb;
				soc_pkg::MASTER_A:
				begin
					// Fetch port is read-only
					bus_q.rw <= 1'b0;
					bus_q.addr <= i_pa_addr;
					bus_q.wdata <= '0;
				end
				default:
					bus_q <= i_pc;
			endcase
		end
		if (state_q == soc_pkg::ARB_BUS && i_bus_ready)
			rdata_q <= i_bus_rdata;
	end

	assign o_bus_req = (state_q == soc_pkg::ARB_BUS);
	assign o_bus = bus_q;

	assign o_pa_ready = (state_q == soc_pkg::ARB_RESP) && (owner_q == soc_pkg::MASTER_A);
	assign o_pb_ready = (state_q == soc_pkg::ARB_RESP) && (owner_q == soc_pkg::MASTER_B);
	assign o_pc_ready = (state_q == soc_pkg::ARB_RESP) && (owner_q == soc_pkg::MASTER_C);

	assign o_pa_rdata = rdata_q;
	assign o_pb_rdata = rdata_q;
	assign o_pc_rdata = rdata_q;

endmodule

`default_nettype wire

// ==== src/soc_fabric.sv ====
`default_nettype none

module soc_fabric (
	input  wire                             clock,
	input  wire                             i_arst_n,
	// Port A, instruction fetch
	input  wire                             i_pa_req,
	input  wire [soc_pkg::addr_w-1:0]       i_pa_addr,
	output logic                            o_pa_ready,
	output logic [soc_pkg::data_w-1:0]      o_pa_rdata,
	// Port B, data
	input  wire                             i_pb_req,
	input  soc_pkg::bus_req_t               i_pb,
	output logic                            o_pb_ready,
	output logic [soc_pkg::data_w-1:0]      o_pb_rdata,
	// Port C, DMA
	input  wire                             i_pc_req,
	input  soc_pkg::bus_req_t               i_pc,
	output logic                            o_pc_ready,
	output logic [soc_pkg::data_w-1:0]      o_pc_rdata,
	output logic [soc_pkg::led_w-1:0]       o_led,
	output logic                            o_timer_irq
);

	// ====================
	// Shared bus
	// ====================
	logic bus_req;
	soc_pkg::bus_req_t bus;
	logic bus_ready;
	logic [soc_pkg::data_w-1:0] bus_rdata;
	soc_pkg::target_sel_t sel;
	logic ram_ready;
	logic [soc_pkg::data_w-1:0] ram_rdata;
	logic regs_ready;
	logic [soc_pkg::data_w-1:0] regs_rdata;

	bus_arbiter u_bus_arbiter (
		.clock       (clock),
		.i_arst_n    (i_arst_n),
		.i_pa_req    (i_pa_req),
		.i_pa_addr   (i_pa_addr),
		.o_pa_ready  (o_pa_ready),
		.o_pa_rdata  (o_pa_rdata),
		.i_pb_req    (i_pb_req),
		.i_pb        (i_pb),
		.o_pb_ready  (o_pb_ready),
		.o_pb_rdata  (o_pb_rdata),
		.i_pc_req    (i_pc_req),
		.i_pc        (i_pc),
		.o_pc_ready  (o_pc_ready),
		.o_pc_rdata  (o_pc_rdata),
		.o_bus_req   (bus_req),
		.o_bus       (bus),
		.i_bus_ready (bus_ready),
		.i_bus_rdata (bus_rdata)
	);

	address_decoder u_address_decoder (
		.clock        (clock),
		.i_arst_n     (i_arst_n),
		.i_bus_req    (bus_req),
		.i_bus        (bus),
		.o_sel        (sel),
		.o_bus_ready  (bus_ready),
		.o_bus_rdata  (bus_rdata),
		.i_ram_ready  (ram_ready),
		.i_ram_rdata  (ram_rdata),
		.i_regs_ready (regs_ready),
		.i_regs_rdata (regs_rdata)
	);

	// ====================
	// Targets
	// ====================
	block_ram u_block_ram (
		.clock    (clock),
		.i_arst_n (i_arst_n),
		.i_sel    (sel.ram),
		.i_bus    (bus),
		.o_ready  (ram_ready),
		.o_rdata  (ram_rdata)
	);

	system_regs u_system_regs (
		.clock       (clock),
		.i_arst_n    (i_arst_n),
		.i_led_sel   (sel.led),
		.i_timer_sel (sel.timer),
		.i_bus       (bus),
		.o_ready     (regs_ready),
		.o_rdata     (regs_rdata),
		.o_led       (o_led),
		.o_timer_irq (o_timer_irq)
	);

endmodule

`default_nettype wire

// ==== src/soc_pkg.sv ====
`default_nettype none

package soc_pkg;

	// ====================
	// Bus geometry
	// ====================
	localparam int addr_w = 32;
	localparam int data_w = 32;

	// Top nibble picks the target
	localparam int region_msb = 31;
	localparam int region_lsb = 28;

	localparam int ram_words = 512;
	localparam int ram_addr_w = 9;

	localparam int led_w = 10;

	// ====================
	// Encodings
	// ====================
	typedef enum logic [3:0] {
		REGION_RAM   = 4'h1,
		REGION_LED   = 4'h4,
		REGION_TIMER = 4'hA
	} region_e;

	// Word offset inside the timer block, address bit 2
	typedef enum logic {
		TIMER_COUNT = 1'b0,
		TIMER_CMP   = 1'b1
	} timer_reg_e;

	typedef enum logic [1:0] {
		MASTER_A,
		MASTER_B,
		MASTER_C
	} master_e;

	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_BUS,
		ARB_RESP
	} arb_state_e;

	// ====================
	// Bus bundles
	// ====================
	typedef struct packed {
		logic rw;
		logic [addr_w-1:0] addr;
		logic [data_w-1:0] wdata;
	} bus_req_t;

	// One-hot, already qualified by the bus request
	typedef struct packed {
		logic ram;
		logic led;
		logic timer;
		logic none;
	} target_sel_t;

endpackage

`default_nettype wire

// ==== src/system_regs.sv ====
`default_nettype none

module system_regs (
	input  wire                             clock,
	input  wire                             i_arst_n,
	input  wire                             i_led_sel,
	input  wire                             i_timer_sel,
	input  soc_pkg::bus_req_t               i_bus,
	output logic                            o_ready,
	output logic [soc_pkg::data_w-1:0]      o_rdata,
	output logic [soc_pkg::led_w-1:0]       o_led,
	output logic                            o_timer_irq
);

	logic [soc_pkg::data_w-1:0] count_q;
	logic [soc_pkg::data_w-1:0] cmp_q;
	soc_pkg::timer_reg_e timer_reg;
	logic access;
	logic led_wr;
	logic timer_wr;

	assign timer_reg = soc_pkg::timer_reg_e'(i_bus.addr[2]);

	assign access = (i_led_sel | i_timer_sel) && !o_ready;
	assign led_wr = access && i_led_sel && i_bus.rw;
	assign timer_wr = access && i_timer_sel && i_bus.rw;

	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_ready <= 1'b0;
		else
			o_ready <= access;
	end

	// ====================
	// LED register
	// ====================
	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
			o_led <= '0;
		else if (led_wr)
			o_led <= i_bus.wdata[soc_pkg::led_w-1:0];
	end

	// ====================
	// Machine timer
	// ====================
	always_ff @(posedge clock or negedge i_arst_n)
	begin
		if (!i_arst_n)
		begin
			count_q <= '0;
			cmp_q <= '1;
			o_timer_irq <= 1'b0;
		end
		else
		begin
			if (timer_wr && timer_reg == soc_pkg::TIMER_COUNT)
				count_q <= i_bus.wdata;
			else
				count_q <= count_q + 1'b1;
			if (timer_wr && timer_reg == soc_pkg::TIMER_CMP)
				cmp_q <= i_bus.wdata;
			// Level interrupt, follows the compare
			o_timer_irq <= (count_q >= cmp_q);
		end
	end

	// Read data lines up with the ready pulse
	always_ff @(posedge clock)
	begin
		if (access)
		begin
			if (i_led_sel)
				o_rdata <= {{(soc_pkg::data_w-soc_pkg::led_w){1'b0}}, o_led};
			else if (timer_reg == soc_pkg::TIMER_CMP)
				o_rdata <= cmp_q;
			else
				o_rdata <= count_q;
		end
	end

endmodule

`default_nettype wire

// ==== verification/soc_fabric_checker.sv ====
`default_nettype none

module soc_fabric_checker (
	input  wire                             clock,
	input  wire                             i_arst_n,
	input  wire                             i_pa_req,
	input  wire                             i_pb_req,
	input  wire                             i_pc_req,
	input  wire                             i_pa_ready,
	input  wire                             i_pb_ready,
	input  wire                             i_pc_ready,
	input  wire                             i_bus_req,
	input  wire                             i_bus_ready,
	input  soc_pkg::bus_req_t               i_bus
);

	// ====================
	// Port side
	// ====================
	one_ready: assert property (@(posedge clock) disable iff (!i_arst_n)
		$onehot0({i_pa_ready, i_pb_ready, i_pc_ready}))
		else $error("more than one port ready in the same cycle");

	// Ready only goes to a port that is still asking
	pa_ready_req: assert property (@(posedge clock) disable iff (!i_arst_n)
		i_pa_ready |-> i_pa_req)
		else $error("port A ready without a request");
	pb_ready_req: assert property (@(posedge clock) disable iff (!i_arst_n)
		i_pb_ready |-> i_pb_req)
		else $error("port B ready without a request");
	pc_ready_req: assert property (@(posedge clock) disable iff (!i_arst_n)
		i_pc_ready |-> i_pc_req)
		else $error("port C ready without a request");

	// ====================
	// Bus side
	// ====================
	bus_hold: assert property (@(posedge clock) disable iff (!i_arst_n)
		(i_bus_req && !i_bus_ready) |=> $stable(i_bus))
		else $error("shared bus fields changed while the request was pending");

	reset_quiet: assert property (@(posedge clock)
		$rose(i_arst_n) |-> !i_bus_req)
		else $error("bus request in the first cycle after reset");

endmodule

bind bus_arbiter soc_fabric_checker u_soc_fabric_checker (
	.clock       (clock),
	.i_arst_n    (i_arst_n),
	.i_pa_req    (i_pa_req),
	.i_pb_req    (i_pb_req),
	.i_pc_req    (i_pc_req),
	.i_pa_ready  (o_pa_ready),
	.i_pb_ready  (o_pb_ready),
	.i_pc_ready  (o_pc_ready),
	.i_bus_req   (o_bus_req),
	.i_bus_ready (i_bus_ready),
	.i_bus       (o_bus)
);

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
	output logic o_clock
);

	// Period of 8
	localparam int half_period = 4;

	initial
	begin
		o_clock = 1'b0;
		forever
			#half_period o_clock = ~o_clock;
	end

endmodule

`default_nettype wire

// ==== verification/tb_soc_fabric.sv ====
`default_nettype none

module tb_soc_fabric;

	localparam int port_a = 0;
	localparam int port_b = 1;
	localparam int port_c = 2;
	localparam logic [31:0] lfsr_seed = 32'h5290_3b5f;
	// x^32 + x^22 + x^2 + x + 1
	localparam logic [31:0] lfsr_taps = 32'h8020_0003;
	localparam int n_fill = 16;
	localparam int n_single = 36;
	localparam int n_groups = 10;
	localparam int n_other = 16;
	// Generous per-transfer budget, plus reset and the timer wait
	localparam int max_txn = n_fill + n_single + 3 * n_groups + n_other;
	localparam int timeout_cycles = max_txn * 18 + 200;
	localparam logic [15:0] unmapped_list = 16'hF720;

	logic clock;
	logic arst_n;
	logic pa_req;
	logic [soc_pkg::addr_w-1:0] pa_addr;
	logic pa_ready;
	logic [soc_pkg::data_w-1:0] pa_rdata;
	logic pb_req;
	soc_pkg::bus_req_t pb;
	logic pb_ready;
	logic [soc_pkg::data_w-1:0] pb_rdata;
	logic pc_req;
	soc_pkg::bus_req_t pc;
	logic pc_ready;
	logic [soc_pkg::data_w-1:0] pc_rdata;
	logic [soc_pkg::led_w-1:0] led;
	logic timer_irq;

	// Reference state and outstanding requests per port
	logic [31:0] lfsr_state;
	logic [31:0] ref_ram [soc_pkg::ram_words];
	logic [soc_pkg::led_w-1:0] ref_led;
	int cycle = 0;
	soc_pkg::bus_req_t pend_req [3];
	string pend_name [3];
	bit pend_check [3];
	bit pend_timed [3];
	int issue_cycle [3];
	logic [31:0] captured [3];
	int order_q [$];
	logic [2:0] ready_vec;
	logic [31:0] rdata_vec [3];

	tb_clock_gen u_clock_gen (
		.o_clock (clock)
	);

	soc_fabric i_soc_fabric (
		.clock       (clock),
		.i_arst_n    (arst_n),
		.i_pa_req    (pa_req),
		.i_pa_addr   (pa_addr),
		.o_pa_ready  (pa_ready),
		.o_pa_rdata  (pa_rdata),
		.i_pb_req    (pb_req),
		.i_pb        (pb),
		.o_pb_ready  (pb_ready),
		.o_pb_rdata  (pb_rdata),
		.i_pc_req    (pc_req),
		.i_pc        (pc),
		.o_pc_ready  (pc_ready),
		.o_pc_rdata  (pc_rdata),
		.o_led       (led),
		.o_timer_irq (timer_irq)
	);

	assign ready_vec = {pc_ready, pb_ready, pa_ready};
	assign rdata_vec[port_a] = pa_rdata;
	assign rdata_vec[port_b] = pb_rdata;
	assign rdata_vec[port_c] = pc_rdata;

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] result;
		logic bit_out;
		int i;
		result = '0;
		for (i = 0; i < count; i++)
		begin
			bit_out = lfsr_state[0];
			lfsr_state = lfsr_state >> 1;
			if (bit_out)
				lfsr_state = lfsr_state ^ lfsr_taps;
			result = {result[30:0], bit_out};
		end
		return result;
	endfunction

	// Sixteen words, random alias bits above the 512-word window
	function automatic soc_pkg::bus_req_t rand_ram_req(input bit allow_write);
		soc_pkg::bus_req_t req;
		logic [31:0] alias_bits;
		logic [31:0] index_bits;
		req.rw = allow_write && (rand_bits(1) == 32'd1);
		alias_bits = rand_bits(17);
		index_bits = rand_bits(4);
		req.addr = {soc_pkg::REGION_RAM, alias_bits[16:0], 5'd0, index_bits[3:0], 2'b00};
		req.wdata = rand_bits(32);
		return req;
	endfunction

	// Expected read data, applied in bus order
	function automatic logic [31:0] ref_access(input soc_pkg::bus_req_t req);
		logic [31:0] result;
		logic [soc_pkg::ram_addr_w-1:0] index;
		result = '0;
		index = req.addr[10:2];
		case (req.addr[31:28])
			soc_pkg::REGION_RAM:
			begin
				result = ref_ram[index];
				if (req.rw)
					ref_ram[index] = req.wdata;
			end
			soc_pkg::REGION_LED:
			begin
				result = 32'(ref_led);
				if (req.rw)
					ref_led = req.wdata[soc_pkg::led_w-1:0];
			end
			// Unmapped reads as zero, timer has its own test
			default:
				result = '0;
		endcase
		return result;
	endfunction

	task automatic check(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("[FAIL] %s expected %h actual %h", name, expected, actual);
			$display("Errors found");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic issue(input int p, input soc_pkg::bus_req_t req, input string name,
		input bit check_data, input bit timed);
		pend_req[p] = req;
		pend_name[p] = name;
		pend_check[p] = check_data;
		pend_timed[p] = timed;
		issue_cycle[p] = cycle;
		case (p)
			port_a:
			begin
				pa_req = 1'b1;
				pa_addr = req.addr;
			end
			port_b:
			begin
				pb_req = 1'b1;
				pb = req;
			end
			default:
			begin
				pc_req = 1'b1;
				pc = req;
			end
		endcase
	endtask

	task automatic drop_req(input int p);
		case (p)
			port_a:
				pa_req = 1'b0;
			port_b:
				pb_req = 1'b0;
			default:
				pc_req = 1'b0;
		endcase
	endtask

	// Release each port the cycle after its ready, in completion order
	task automatic collect(input int count);
		int k;
		int p;
		for (k = 0; k < count; k++)
		begin
			while (order_q.size() <= k)
				@(posedge clock);
			p = order_q[k];
			@(negedge clock);
			drop_req(p);
		end
	endtask

	task automatic run_single(input int p, input soc_pkg::bus_req_t req, input string name,
		input bit check_data);
		order_q.delete();
		issue(p, req, name, check_data, 1'b1);
		collect(1);
	endtask

	// ====================
	// Compare and timeout
	// ====================
	always @(negedge clock)
	begin
		logic [31:0] expected;
		int p;
		for (p = 0; p < 3; p++)
		begin
			if (ready_vec[p])
			begin
				expected = ref_access(pend_req[p]);
				captured[p] = rdata_vec[p];
				if (pend_check[p] && !pend_req[p].rw)
					check(pend_name[p], expected, rdata_vec[p]);
				if (pend_timed[p])
					check({pend_name[p], " latency"}, 32'd3, cycle - issue_cycle[p]);
				order_q.push_back(p);
			end
		end
	end

	always @(posedge clock)
	begin
		cycle = cycle + 1;
		if (cycle >= timeout_cycles)
		begin
			$display("Timeout after %0d cycles, a transfer never completed", cycle);
			$display("Errors found");
			$fatal(1, "timeout");
		end
	end

	// ====================
	// Stimulus
	// ====================
	initial
	begin
		int i;
		int k;
		int p;
		int count;
		int waited;
		int exp_order [3];
		logic [31:0] bits;
		logic [31:0] mask;
		logic [3:0] region;
		soc_pkg::bus_req_t req;
		lfsr_state = lfsr_seed;
		ref_led = '0;
		arst_n = 1'b0;
		pa_req = 1'b0;
		pa_addr = '0;
		pb_req = 1'b0;
		pb = '0;
		pc_req = 1'b0;
		pc = '0;
		repeat (8) @(negedge clock);
		arst_n = 1'b1;
		@(negedge clock);

		// Known contents for the words the random tests touch
		for (i = 0; i < n_fill; i++)
		begin
			req = rand_ram_req(1'b1);
			req.rw = 1'b1;
			req.addr[5:2] = i[3:0];
			run_single((i % 2 == 0) ? port_b : port_c, req, "RAM fill write", 1'b0);
		end

		for (i = 0; i < n_single; i++)
		begin
			bits = rand_bits(2);
			p = (bits == 0) ? port_a : (bits == 1) ? port_b : port_c;
			req = rand_ram_req(p != port_a);
			run_single(p, req, "single RAM access", 1'b1);
		end

		// Same-cycle requests, expected B then A then C
		for (i = 0; i < n_groups; i++)
		begin
			mask = rand_bits(3);
			if (mask[2:0] == 3'b000)
				mask = 32'd7;
			order_q.delete();
			count = 0;
			if (mask[1])
			begin
				issue(port_b, rand_ram_req(1'b1), "group port B", 1'b1, 1'b0);
				exp_order[count] = port_b;
				count++;
			end
			if (mask[0])
			begin
				issue(port_a, rand_ram_req(1'b0), "group port A", 1'b1, 1'b0);
				exp_order[count] = port_a;
				count++;
			end
			if (mask[2])
			begin
				issue(port_c, rand_ram_req(1'b1), "group port C", 1'b1, 1'b0);
				exp_order[count] = port_c;
				count++;
			end
			collect(count);
			for (k = 0; k < count; k++)
				check("group priority order", exp_order[k], order_q[k]);
		end

		req = '0;
		req.rw = 1'b1;
		req.addr = {soc_pkg::REGION_LED, 28'h0};
		req.wdata = rand_bits(32);
		run_single(port_b, req, "LED write", 1'b0);
		check("LED output", 32'(req.wdata[soc_pkg::led_w-1:0]), 32'(led));
		req.rw = 1'b0;
		run_single(port_c, req, "LED read", 1'b1);

		for (i = 0; i < 4; i++)
		begin
			region = unmapped_list[i*4 +: 4];
			bits = rand_bits(28);
			req.rw = 1'b1;
			req.addr = {region, bits[27:0]};
			req.wdata = rand_bits(32);
			run_single(port_c, req, "unmapped write", 1'b0);
			req.rw = 1'b0;
			run_single(port_b, req, "unmapped read", 1'b1);
		end
		check("LED after unmapped writes", 32'(ref_led), 32'(led));

		// Timer compare at 40 from a cleared counter
		req.rw = 1'b1;
		req.addr = {soc_pkg::REGION_TIMER, 28'h0};
		req.wdata = '0;
		run_single(port_b, req, "timer count write", 1'b0);
		req.addr[2] = soc_pkg::TIMER_CMP;
		req.wdata = 32'd40;
		run_single(port_b, req, "timer compare write", 1'b0);
		waited = 0;
		while (!timer_irq && waited < 60)
		begin
			@(negedge clock);
			waited++;
		end
		check("timer irq rise", 32'd1, 32'(timer_irq));
		check("timer irq not early", 32'd1, 32'(waited >= 30));
		req.rw = 1'b0;
		req.addr[2] = soc_pkg::TIMER_COUNT;
		run_single(port_b, req, "timer count read", 1'b0);
		check("timer count at least 40", 32'd1, 32'(captured[port_b] >= 40));
		req.rw = 1'b1;
		req.addr[2] = soc_pkg::TIMER_CMP;
		req.wdata = '1;
		run_single(port_b, req, "timer compare clear", 1'b0);
		@(negedge clock);
		check("timer irq cleared", 32'd0, 32'(timer_irq));

		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire
